// ==== rs_pkg.sv ====
package rs_pkg;

    localparam int DATA_SYMS = 64;
    localparam int N68       = 68;   // detection word length
    localparam int N72       = 72;   // correction word length
    localparam int NSYN      = 4;

    typedef logic [7:0]             symbol_t;
    typedef logic [DATA_SYMS*8-1:0] data_word_t;
    typedef logic [N68*8-1:0]       code68_t;
    typedef logic [N72*8-1:0]       code72_t;
    typedef logic [6:0]             sym_idx_t;
    typedef logic [3:0]             err_count_t;

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_SINGLE,
        ERR_MULTI
    } err_class_t;

    // x^8 + x^4 + x^3 + x^2 + 1
    localparam symbol_t GF_POLY_LOW = 8'h1D;
    localparam symbol_t ALPHA       = 8'h02;

    // shift-and-add product, reduced on every shift
    function automatic symbol_t gf_mul(symbol_t a, symbol_t b);
        symbol_t prod;
        symbol_t x;
        prod = '0;
        x    = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ x;
            end
            if (x[7]) begin
                x = symbol_t'(x << 1) ^ GF_POLY_LOW;
            end else begin
                x = symbol_t'(x << 1);
            end
        end
        return prod;
    endfunction

endpackage

// ==== rs_ifs.sv ====
`timescale 1ns/10ps

// shared symbol index between the FSM and the datapath units
interface counter_if;
    import rs_pkg::*;

    logic     clear;
    logic     step;
    sym_idx_t idx;
    logic     last;   // idx at N68-1

    modport ctrl (output clear, output step, input last);
    modport cnt  (input clear, input step, output idx, output last);
    modport user (input clear, input step, input idx, input last);

endinterface

interface syndrome_if;
    import rs_pkg::*;

    symbol_t s0;
    symbol_t s1;
    symbol_t s2;
    symbol_t s3;

    modport src  (output s0, output s1, output s2, output s3);
    modport sink (input s0, input s1, input s2, input s3);

endinterface

// ==== symbol_counter.sv ====
`timescale 1ns/10ps

module symbol_counter (
    input  logic      clk,
    input  logic      rst_n,
    counter_if.cnt    cnt
);
    import rs_pkg::*;

    sym_idx_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (cnt.clear) begin   // clear wins over step
            count <= '0;
        end else if (cnt.step) begin
            count <= count + 1'b1;
        end
    end

    assign cnt.idx  = count;
    assign cnt.last = (count == sym_idx_t'(N68 - 1));

endmodule

// ==== syndrome_unit.sv ====
`timescale 1ns/10ps

module syndrome_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  rs_pkg::code68_t received,
    input  logic           clear,
    counter_if.user        cnt,
    syndrome_if.src        syn
);
    import rs_pkg::*;

    symbol_t acc    [NSYN];
    symbol_t scaled [NSYN];
    symbol_t sym;
    logic    active;   // high only for the 68 syndrome steps

    // symbol 0 sits in the low byte and carries the highest degree
    always_comb begin
        if (cnt.idx < N68) begin
            sym = received[8*cnt.idx +: 8];
        end else begin
            sym = '0;
        end
    end

    // acc[j] * alpha^j for the horner step
    always_comb begin
        for (int j = 0; j < NSYN; j++) begin
            scaled[j] = acc[j];
            for (int k = 0; k < j; k++) begin
                scaled[j] = gf_mul(scaled[j], ALPHA);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
        end else if (clear) begin
            active <= 1'b1;
        end else if (active && cnt.step && cnt.last) begin
            active <= 1'b0;   // search steps must not touch the sums
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int j = 0; j < NSYN; j++) begin
                acc[j] <= '0;
            end
        end else if (active && cnt.step) begin
            for (int j = 0; j < NSYN; j++) begin
                acc[j] <= scaled[j] ^ sym;
            end
        end
    end

    assign syn.s0 = acc[0];
    assign syn.s1 = acc[1];
    assign syn.s2 = acc[2];
    assign syn.s3 = acc[3];

endmodule

// ==== error_locator.sv ====
`timescale 1ns/10ps

module error_locator (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              search,
    input  logic              load,
    counter_if.user           cnt,
    syndrome_if.sink          syn,
    output rs_pkg::err_class_t err_class,
    output rs_pkg::sym_idx_t  err_pos,
    output rs_pkg::symbol_t   err_value,
    output logic              locate_done
);
    import rs_pkg::*;

    symbol_t srch;         // S0 * alpha^k on search step k
    logic    all_zero;
    logic    match;
    logic    consistent;
    logic    first;

    assign all_zero = ((syn.s0 | syn.s1 | syn.s2 | syn.s3) == '0);
    assign match    = (srch == syn.s1);
    assign first    = (cnt.idx == '0);

    // a single error gives a geometric syndrome sequence
    assign consistent = (gf_mul(syn.s0, syn.s2) == gf_mul(syn.s1, syn.s1)) &&
                        (gf_mul(syn.s1, syn.s3) == gf_mul(syn.s2, syn.s2));

    always_ff @(posedge clk) begin
        if (load) begin
            srch      <= syn.s0;
            err_value <= syn.s0;   // error magnitude of a single error
        end else if (search) begin
            srch <= gf_mul(srch, ALPHA);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_class   <= ERR_NONE;
            err_pos     <= '0;
            locate_done <= 1'b0;
        end else if (load) begin
            err_class   <= ERR_NONE;
            err_pos     <= '0;
            locate_done <= 1'b0;
        end else if (search) begin
            if (first && all_zero) begin
                err_class   <= ERR_NONE;
                locate_done <= 1'b1;
            end else if (match && consistent) begin
                err_class   <= ERR_SINGLE;
                err_pos     <= sym_idx_t'(N68 - 1) - cnt.idx;   // step k -> degree k
                locate_done <= 1'b1;
            end else if (match || cnt.last) begin
                // inconsistent match or no root in range
                err_class   <= ERR_MULTI;
                locate_done <= 1'b1;
            end
        end
    end

endmodule

// ==== symbol_corrector.sv ====
`timescale 1ns/10ps

module symbol_corrector (
    input  logic               clk,
    input  logic               rst_n,
    input  rs_pkg::code68_t    word68,
    input  rs_pkg::code72_t    word72,
    input  logic               load,
    input  logic               apply,
    input  rs_pkg::sym_idx_t   err_pos,
    input  rs_pkg::symbol_t    err_value,
    output rs_pkg::data_word_t data,
    output logic               corrected
);
    import rs_pkg::*;

    sym_idx_t   mapped;    // position inside the 72-symbol word
    logic       fixable;
    data_word_t patched;

    always_comb begin
        if (err_pos < DATA_SYMS) begin
            mapped = err_pos;
        end else begin
            mapped = err_pos + sym_idx_t'(N72 - N68);   // skip the extra parity
        end
        fixable = (mapped < DATA_SYMS);
        patched = word72[DATA_SYMS*8-1:0];
        if (fixable) begin
            patched[8*mapped[5:0] +: 8] = patched[8*mapped[5:0] +: 8] ^ err_value;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data <= word68[DATA_SYMS*8-1:0];
        end else if (apply && fixable) begin
            data <= patched;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            corrected <= 1'b0;
        end else if (load) begin
            corrected <= 1'b0;
        end else if (apply && fixable) begin
            corrected <= 1'b1;
        end
    end

endmodule

// ==== decode_ctrl.sv ====
`timescale 1ns/10ps

module decode_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    counter_if.ctrl            cnt,
    output logic               syn_clear,
    output logic               search,
    output logic               loc_load,
    output logic               cor_load,
    output logic               cor_apply,
    input  logic               locate_done,
    input  rs_pkg::err_class_t err_class,
    input  logic               corrected,
    input  rs_pkg::sym_idx_t   err_pos,
    output rs_pkg::err_count_t errors_detected,
    output rs_pkg::sym_idx_t   error_position,
    output logic               decode_success,
    output logic               valid_out
);
    import rs_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SYNDROME,
        ST_LOCATE,
        ST_CORRECT,
        ST_DONE
    } state_t;

    state_t state;
    logic   loaded;   // locator seeded, search may run

    always_comb begin
        cnt.clear = 1'b0;
        cnt.step  = 1'b0;
        syn_clear = 1'b0;
        search    = 1'b0;
        loc_load  = 1'b0;
        cor_load  = 1'b0;
        cor_apply = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    cnt.clear = 1'b1;
                    syn_clear = 1'b1;
                    cor_load  = 1'b1;
                end
            end
            ST_SYNDROME: cnt.step = 1'b1;
            ST_LOCATE: begin
                if (!loaded) begin
                    loc_load  = 1'b1;
                    cnt.clear = 1'b1;   // k restarts at 0
                end else if (!locate_done) begin
                    search   = 1'b1;
                    cnt.step = 1'b1;
                end
            end
            ST_CORRECT: cor_apply = (err_class == ERR_SINGLE);
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ST_IDLE;
            loaded          <= 1'b0;
            errors_detected <= '0;
            error_position  <= '0;
            decode_success  <= 1'b0;
            valid_out       <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state           <= ST_SYNDROME;
                        errors_detected <= '0;
                        error_position  <= '0;
                        decode_success  <= 1'b0;
                    end
                end
                ST_SYNDROME: begin
                    if (cnt.last) begin   // 68th symbol this cycle
                        state  <= ST_LOCATE;
                        loaded <= 1'b0;
                    end
                end
                ST_LOCATE: begin
                    if (!loaded) begin
                        loaded <= 1'b1;
                    end else if (locate_done) begin
                        state <= ST_CORRECT;
                    end
                end
                ST_CORRECT: begin
                    case (err_class)
                        ERR_NONE:   errors_detected <= err_count_t'(0);
                        ERR_SINGLE: errors_detected <= err_count_t'(1);
                        default:    errors_detected <= err_count_t'(2);
                    endcase
                    error_position <= (err_class == ERR_SINGLE) ? err_pos : '0;
                    state          <= ST_DONE;
                end
                ST_DONE: begin
                    if (!valid_out) begin
                        valid_out      <= 1'b1;
                        // a repaired word always counts as success
                        decode_success <= corrected || (err_class != ERR_MULTI);
                    end else if (!start) begin
                        valid_out <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== crs_decoder.sv ====
`timescale 1ns/10ps

module crs_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  rs_pkg::code72_t    received_data_72,
    input  rs_pkg::code68_t    received_data_68,
    output rs_pkg::data_word_t decoded_data,
    output rs_pkg::err_count_t errors_detected,
    output logic               errors_corrected,
    output rs_pkg::sym_idx_t   error_position,
    output logic               valid_out,
    output logic               decode_success
);
    import rs_pkg::*;

    logic       syn_clear;
    logic       search;
    logic       loc_load;
    logic       cor_load;
    logic       cor_apply;
    logic       locate_done;
    err_class_t err_class;
    sym_idx_t   err_pos;
    symbol_t    err_value;

    counter_if  cnt_if ();
    syndrome_if syn_if ();

    decode_ctrl ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .cnt             (cnt_if.ctrl),
        .syn_clear       (syn_clear),
        .search          (search),
        .loc_load        (loc_load),
        .cor_load        (cor_load),
        .cor_apply       (cor_apply),
        .locate_done     (locate_done),
        .err_class       (err_class),
        .corrected       (errors_corrected),
        .err_pos         (err_pos),
        .errors_detected (errors_detected),
        .error_position  (error_position),
        .decode_success  (decode_success),
        .valid_out       (valid_out)
    );

    symbol_counter counter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cnt   (cnt_if.cnt)
    );

    // syndromes come from the 68-symbol word only
    syndrome_unit syndrome_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .received (received_data_68),
        .clear    (syn_clear),
        .cnt      (cnt_if.user),
        .syn      (syn_if.src)
    );

    error_locator locator_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .search      (search),
        .load        (loc_load),
        .cnt         (cnt_if.user),
        .syn         (syn_if.sink),
        .err_class   (err_class),
        .err_pos     (err_pos),
        .err_value   (err_value),
        .locate_done (locate_done)
    );

    symbol_corrector corrector_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .word68    (received_data_68),
        .word72    (received_data_72),
        .load      (cor_load),
        .apply     (cor_apply),
        .err_pos   (err_pos),
        .err_value (err_value),
        .data      (decoded_data),
        .corrected (errors_corrected)
    );

endmodule

// ==== crs_decoder_chk.sv ====
`timescale 1ns/10ps

module crs_decoder_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               start,
    input logic               valid_out,
    input logic               decode_success,
    input logic               errors_corrected,
    input rs_pkg::err_count_t errors_detected,
    input rs_pkg::sym_idx_t   error_position,
    input rs_pkg::data_word_t decoded_data
);

    valid_release: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && !start |=> !valid_out)
        else $error("valid_out still high a cycle after start was released");

    // a repair is always a single error and a success
    corrected_single: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && errors_corrected |-> decode_success && errors_detected == 1)
        else $error("errors_corrected without a successful single error");

    count_range: assert property (@(posedge clk) disable iff (!rst_n)
        errors_detected <= 2)
        else $error("errors_detected above 2");

    held_results: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out && start |=> valid_out && $stable({decoded_data, errors_detected,
            errors_corrected, error_position, decode_success}))
        else $error("results changed while start held the decoder in done");

endmodule

bind crs_decoder crs_decoder_chk crs_decoder_chk_i (.*);

// ==== tb_crs_decoder.sv ====
`timescale 1ns/10ps

module tb_crs_decoder;
    import rs_pkg::*;

    localparam int MAX_DECODES   = 40;
    localparam int DECODE_CYCLES = 160;   // worst case decode plus release
    localparam int CYCLE_LIMIT   = MAX_DECODES * DECODE_CYCLES + 100;

    logic       clk;
    logic       rst_n;
    logic       start;
    code72_t    received_data_72;
    code68_t    received_data_68;
    data_word_t decoded_data;
    err_count_t errors_detected;
    logic       errors_corrected;
    sym_idx_t   error_position;
    logic       valid_out;
    logic       decode_success;

    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    symbol_t exp_tab [255];
    int      log_tab [256];
    symbol_t gen     [4];   // generator terms below x^4

    crs_decoder crs_decoder_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: decoder gave no result within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    function automatic void build_tables();
        symbol_t v;
        v = 8'h01;
        for (int i = 0; i < 255; i++) begin
            exp_tab[i] = v;
            log_tab[v] = i;
            v = {v[6:0], 1'b0} ^ (v[7] ? 8'h1D : 8'h00);   // times x mod 0x11D
        end
    endfunction

    function automatic symbol_t gf_times(symbol_t a, symbol_t b);
        if (a == 8'h00 || b == 8'h00) begin
            return 8'h00;
        end
        return exp_tab[(log_tab[a] + log_tab[b]) % 255];
    endfunction

    // product of (x + alpha^j) for j = 0..3
    function automatic void build_generator();
        symbol_t g [5];
        for (int k = 0; k < 5; k++) begin
            g[k] = (k == 0) ? 8'h01 : 8'h00;
        end
        for (int j = 0; j < NSYN; j++) begin
            for (int k = 4; k > 0; k--) begin
                g[k] = g[k-1] ^ gf_times(exp_tab[j], g[k]);
            end
            g[0] = gf_times(exp_tab[j], g[0]);
        end
        for (int k = 0; k < 4; k++) begin
            gen[k] = g[k];
        end
    endfunction

    function automatic code68_t encode(data_word_t data);
        code68_t cw;
        symbol_t r [4];
        symbol_t fb;
        cw = '0;
        cw[DATA_SYMS*8-1:0] = data;
        for (int k = 0; k < 4; k++) begin
            r[k] = 8'h00;
        end
        for (int i = 0; i < DATA_SYMS; i++) begin
            fb   = data[8*i +: 8] ^ r[3];   // symbol 0 is the highest degree
            r[3] = r[2] ^ gf_times(fb, gen[3]);
            r[2] = r[1] ^ gf_times(fb, gen[2]);
            r[1] = r[0] ^ gf_times(fb, gen[1]);
            r[0] = gf_times(fb, gen[0]);
        end
        for (int k = 0; k < 4; k++) begin
            cw[8*(DATA_SYMS+k) +: 8] = r[3-k];
        end
        return cw;
    endfunction

    // s_j is the sum of r_i * alpha^(j*(67-i)), s0 in the low byte
    function automatic logic [31:0] syndromes(code68_t w);
        logic [31:0] s;
        s = '0;
        for (int j = 0; j < NSYN; j++) begin
            for (int i = 0; i < N68; i++) begin
                s[8*j +: 8] ^= gf_times(w[8*i +: 8], exp_tab[(j * (N68 - 1 - i)) % 255]);
            end
        end
        return s;
    endfunction

    task automatic predict(input code68_t w68, input code72_t w72, output err_count_t count,
                           output sym_idx_t pos, output logic corr, output logic ok,
                           output data_word_t data);
        logic [31:0] s;
        symbol_t     s0;
        symbol_t     s1;
        symbol_t     s2;
        symbol_t     s3;
        int          hit;
        logic        consistent;
        s  = syndromes(w68);
        s0 = s[7:0];
        s1 = s[15:8];
        s2 = s[23:16];
        s3 = s[31:24];
        hit = -1;
        for (int k = 0; k < N68 && hit < 0; k++) begin
            if (gf_times(s0, exp_tab[k]) == s1) begin
                hit = k;
            end
        end
        consistent = (gf_times(s0, s2) == gf_times(s1, s1)) &&
                     (gf_times(s1, s3) == gf_times(s2, s2));
        count = 0;
        pos   = 0;
        corr  = 1'b0;
        ok    = 1'b1;
        data  = w68[DATA_SYMS*8-1:0];
        if (s == 32'h0) begin
            count = 0;
        end else if (hit >= 0 && consistent) begin
            count = 1;
            pos   = sym_idx_t'(N68 - 1 - hit);
            if (pos < DATA_SYMS) begin   // data positions match in both words
                corr = 1'b1;
                data = w72[DATA_SYMS*8-1:0];
                data[8*pos +: 8] ^= s0;
            end
        end else begin
            count = 2;
            ok    = 1'b0;
        end
    endtask

    function automatic data_word_t random_data();
        data_word_t d;
        for (int w = 0; w < DATA_SYMS / 4; w++) begin
            d[32*w +: 32] = $urandom;
        end
        return d;
    endfunction

    function automatic code72_t widen(code68_t w68);
        return {$urandom, $urandom, w68[DATA_SYMS*8-1:0]};
    endfunction

    task automatic compare(string name, logic [575:0] actual, logic [575:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // entered on a falling edge with the decoder idle
    task automatic decode(code68_t w68, code72_t w72, err_count_t exp_count,
                          sym_idx_t exp_pos, logic exp_corr, logic exp_ok,
                          data_word_t exp_data);
        received_data_68 = w68;
        received_data_72 = w72;
        start            = 1'b1;
        @(negedge clk);
        while (!valid_out) begin
            @(negedge clk);
        end
        compare("errors_detected", errors_detected, exp_count);
        compare("error_position", error_position, exp_pos);
        compare("errors_corrected", errors_corrected, exp_corr);
        compare("decode_success", decode_success, exp_ok);
        compare("decoded_data", decoded_data, exp_data);
        @(negedge clk);
        compare("valid_out", valid_out, 1'b1);   // held while start stays high
        start = 1'b0;
        @(negedge clk);
        compare("valid_out", valid_out, 1'b0);
    endtask

    task automatic reset_state();
        compare("valid_out", valid_out, 1'b0);
        compare("decode_success", decode_success, 1'b0);
        compare("errors_corrected", errors_corrected, 1'b0);
        compare("errors_detected", errors_detected, '0);
        compare("error_position", error_position, '0);
    endtask

    task automatic clean_words(int n);
        data_word_t d;
        code68_t    w;
        for (int t = 0; t < n; t++) begin
            d = random_data();
            w = encode(d);
            compare("model syndromes", syndromes(w), '0);
            decode(w, widen(w), 0, 0, 1'b0, 1'b1, d);
            @(negedge clk);
        end
    endtask

    task automatic data_errors(int n);
        data_word_t d;
        code68_t    w;
        int         p;
        for (int t = 0; t < n; t++) begin
            d = random_data();
            w = encode(d);
            p = $urandom_range(DATA_SYMS - 1, 0);
            w[8*p +: 8] ^= symbol_t'($urandom_range(255, 1));
            decode(w, widen(w), 1, sym_idx_t'(p), 1'b1, 1'b1, d);
            @(negedge clk);
        end
    endtask

    task automatic parity_errors();
        data_word_t d;
        code68_t    w;
        for (int q = DATA_SYMS; q < N68; q++) begin
            d = random_data();
            w = encode(d);
            w[8*q +: 8] ^= symbol_t'($urandom_range(255, 1));
            decode(w, widen(w), 1, sym_idx_t'(q), 1'b0, 1'b1, d);
            @(negedge clk);
        end
    endtask

    task automatic double_errors(int n);
        code68_t    w;
        code72_t    w72;
        int         p;
        int         q;
        err_count_t count;
        sym_idx_t   pos;
        logic       corr;
        logic       ok;
        data_word_t exp_data;
        for (int t = 0; t < n; t++) begin
            w = encode(random_data());
            p = $urandom_range(N68 - 1, 0);
            q = $urandom_range(N68 - 1, 0);
            while (q == p) begin
                q = $urandom_range(N68 - 1, 0);
            end
            w[8*p +: 8] ^= symbol_t'($urandom_range(255, 1));
            w[8*q +: 8] ^= symbol_t'($urandom_range(255, 1));
            w72 = widen(w);
            predict(w, w72, count, pos, corr, ok, exp_data);
            decode(w, w72, count, pos, corr, ok, exp_data);
            @(negedge clk);
        end
    endtask

    // no idle gap, start rises on the edge where valid_out was seen low
    task automatic back_to_back(int n);
        data_word_t d;
        code68_t    w;
        int         p;
        for (int t = 0; t < n; t++) begin
            d = random_data();
            w = encode(d);
            if (t % 2 == 0) begin
                decode(w, widen(w), 0, 0, 1'b0, 1'b1, d);
            end else begin
                p = $urandom_range(DATA_SYMS - 1, 0);
                w[8*p +: 8] ^= symbol_t'($urandom_range(255, 1));
                decode(w, widen(w), 1, sym_idx_t'(p), 1'b1, 1'b1, d);
            end
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        start            = 1'b0;
        received_data_68 = '0;
        received_data_72 = '0;
        void'($urandom(87));
        build_tables();
        build_generator();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_state();
        clean_words(8);
        data_errors(10);
        parity_errors();
        double_errors(8);
        back_to_back(6);
        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
rs_pkg.sv
rs_ifs.sv
symbol_counter.sv
syndrome_unit.sv
error_locator.sv
symbol_corrector.sv
decode_ctrl.sv
crs_decoder.sv
crs_decoder_chk.sv
tb_crs_decoder.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := tb_crs_decoder
FILELIST    := list.f
BUILD_FLAGS := --binary --assert --timing -Wno-fatal
LINT_FLAGS  := --lint-only -Wall --timing
OBJ_DIR     := obj_dir
LOG         := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Errors found" $(LOG)
	@grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
